// ==== norm_check_top.f ====
+incdir+.
norm_check_pkg.sv
norm_check_ctrl.sv
norm_check_unit.sv
coeff_mem_arbiter.sv
coeff_mem.sv
norm_axil_regs.sv
norm_check_top.sv
norm_check_assertions.sv
norm_check_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run norm_check_tb with Verilator; sim.log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# A failed build or an aborted run also counts as failure in the log
verilator --binary --timing --assert --top-module norm_check_tb \
    -f norm_check_top.f -o norm_check_sim \
    && ./obj_dir/norm_check_sim > sim.log 2>&1 \
    || echo "Test failed" >> sim.log

grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || echo "PASS"

// ==== norm_check_tb.sv ====
// Memory has no reset so each checked word is written first; the window reaches words below 768
`default_nettype none

`include "norm_check_config.svh"

module norm_check_tb;
    import norm_check_pkg::*;

    localparam int AW        = `NC_AXI_ADDR_W;
    localparam int WPP       = `NC_N / `NC_LANES;
    localparam int Z_WORDS   = `NC_L * WPP;
    localparam int K_WORDS   = `NC_K * WPP;
    // Words reachable through the window above WIN_BASE
    localparam int WIN_WORDS = ((1 << AW) - int'(WIN_BASE)) / 16;
    // Rough cycles per window word, four lanes plus the memory grant
    localparam int LOAD_COST = 16;

    logic                        clk;
    logic                        reset_n;
    logic [AW-1:0]               awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [`NC_AXI_DATA_W-1:0]   wdata;
    logic [`NC_AXI_DATA_W/8-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;
    logic [AW-1:0]               araddr;
    logic                        arvalid;
    logic                        arready;
    logic [`NC_AXI_DATA_W-1:0]   rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;

    // Reference copy of the memory, one entry per coefficient
    int unsigned coeffs [`NC_MEM_DEPTH * `NC_LANES];
    int          checks;
    int          errors;
    int          test_errors;
    int          base;
    int unsigned rbase;
    logic [31:0] st;
    logic        exp_bad;

    norm_check_top dut0 (.*);

    // Lands on dut0.arb0, the only arbiter instance
    bind coeff_mem_arbiter norm_check_assertions arb_sva0 (
        .clk, .reset_n,
        .gnt_a (ld_gnt), .gnt_b (chk_gnt),
        .req_a (ld_req), .req_b (chk_req),
        .rd_valid,
        .flag_a (1'b0), .flag_b (1'b0)
    );

    // Lands on dut0.ctrl0
    bind norm_check_ctrl norm_check_assertions ctrl_sva0 (
        .clk, .reset_n,
        .gnt_a (1'b0), .gnt_b (chk_gnt),
        .req_a ('0), .req_b (chk_req),
        .rd_valid (1'b0),
        .flag_a (busy), .flag_b (done_pulse)
    );

    always #5 clk = ~clk;

    // Centered magnitude against the bound, out-of-range values always bad
    function automatic logic lane_bad(input int unsigned c, input int unsigned bound);
        int unsigned mag;
        if (c >= `NC_Q) begin
            return 1'b1;
        end
        mag = (c <= (`NC_Q - 1) / 2) ? c : `NC_Q - c;
        return mag >= bound;
    endfunction

    function automatic logic expected_invalid(input chk_norm_mode_e mode, input int vbase);
        int          words;
        int unsigned bound;
        logic        bad;
        bad   = 1'b0;
        words = 0;
        bound = `NC_Q;
        case (mode)
            z_bound: begin
                words = Z_WORDS;
                bound = `NC_Z_BOUND;
            end
            r0_bound: begin
                words = K_WORDS;
                bound = `NC_R0_BOUND;
            end
            ct0_bound: begin
                words = K_WORDS;
                bound = `NC_CT0_BOUND;
            end
            default: words = 0;
        endcase
        for (int w = 0; w < words; w++) begin
            for (int l = 0; l < `NC_LANES; l++) begin
                bad = bad | lane_bad(
                    coeffs[((vbase + w) % `NC_MEM_DEPTH) * `NC_LANES + l], bound);
            end
        end
        return bad;
    endfunction

    // Magnitude below the bound with a random sign
    function automatic int unsigned pick_coeff(input int unsigned bound);
        int unsigned mag;
        mag = $urandom_range(bound - 1, 0);
        if (mag != 0 && $urandom_range(1, 0) == 1) begin
            return `NC_Q - mag;
        end
        return mag;
    endfunction

    // Cycle allowance for loads plus checks
    function automatic int budget(input int load_words, input int check_words, input int n_checks);
        return load_words * LOAD_COST + n_checks * (4 * check_words + 2000);
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    // Called 1 unit after a rising edge, returns at the same point
    task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // AW and W go in together
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Window words hold the response until the memory grant
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        // Always OKAY
        compare("write_response", 32'd0, 32'(bresp));
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        compare("read_response", 32'd0, 32'(rresp));
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Lane 3 last, it issues the word
    task automatic store_word(input int word);
        for (int l = 0; l < `NC_LANES; l++) begin
            write_reg(WIN_BASE + AW'(word * 16 + l * 4), coeffs[word * `NC_LANES + l]);
        end
    endtask

    task automatic set_coeff(input int word, input int lane, input int unsigned value);
        coeffs[word * `NC_LANES + lane] = value;
        store_word(word);
    endtask

    task automatic fill_region(input int first, input int words, input int unsigned bound);
        for (int w = first; w < first + words; w++) begin
            for (int l = 0; l < `NC_LANES; l++) begin
                coeffs[w * `NC_LANES + l] = pick_coeff(bound);
            end
            store_word(w);
        end
    endtask

    // One unrestricted coefficient somewhere in a region, half the time
    task automatic maybe_outlier(input int first, input int words);
        if ($urandom_range(1, 0) == 1) begin
            set_coeff(first + int'($urandom_range(words - 1, 0)),
                      int'($urandom_range(`NC_LANES - 1, 0)),
                      $urandom_range(32'hFF_FFFF, 0));
        end
    endtask

    task automatic start_check(input chk_norm_mode_e mode, input int vbase);
        write_reg(REG_BASE, 32'(vbase));
        write_reg(REG_CTRL, {28'd0, 1'b0, mode, 1'b1});
    endtask

    // Poll STATUS.done, the watchdog bounds the loop
    task automatic wait_done(output logic [31:0] status);
        read_reg(REG_STATUS, status);
        while (!status[1]) begin
            read_reg(REG_STATUS, status);
        end
    endtask

    task automatic run_check(input string name, input chk_norm_mode_e mode, input int vbase,
                             input logic expect_bad);
        logic [31:0] status;
        start_check(mode, vbase);
        wait_done(status);
        compare(name, 32'(expect_bad), 32'(status[2]));
    endtask

    // Watchdog sized from the tests below
    initial begin
        int limit;
        limit = budget(0, 0, 1)
              + budget(3 * Z_WORDS, Z_WORDS, 3)
              + budget(K_WORDS + 8, Z_WORDS, 4)
              + budget(8, K_WORDS, 4)
              + budget(WIN_WORDS - Z_WORDS + 8, Z_WORDS, 2)
              + budget(8, K_WORDS, 2);
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles before all tests finished", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '1;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        void'($urandom(16));
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Registers straight out of reset
        read_reg(REG_STATUS, st);
        compare("status_after_reset", 32'd0, st);
        rbase = $urandom_range(`NC_MEM_DEPTH - 1, 0);
        write_reg(REG_BASE, rbase);
        read_reg(REG_BASE, st);
        compare("base_readback", rbase, st);
        report_test("registers");

        // Random z vectors at random bases
        for (int i = 0; i < 3; i++) begin
            base = int'($urandom_range(WIN_WORDS - Z_WORDS, 0));
            fill_region(base, Z_WORDS, `NC_Z_BOUND);
            maybe_outlier(base, Z_WORDS);
            run_check($sformatf("z_random_%0d", i), z_bound, base,
                      expected_invalid(z_bound, base));
        end
        report_test("z_random");

        // Clean region for all modes over words 0..511
        fill_region(0, K_WORDS, `NC_R0_BOUND);
        set_coeff(0, 0, `NC_Z_BOUND - 1);
        run_check("edge_bound_minus_1", z_bound, 0, 1'b0);
        set_coeff(0, 0, 0);
        set_coeff(Z_WORDS - 1, 3, `NC_Z_BOUND);
        run_check("edge_bound_last_lane", z_bound, 0, 1'b1);
        set_coeff(Z_WORDS - 1, 3, `NC_Q - `NC_Z_BOUND);
        run_check("edge_q_minus_bound", z_bound, 0, 1'b1);
        set_coeff(Z_WORDS - 1, 3, 0);
        set_coeff(Z_WORDS, 0, `NC_Z_BOUND);
        run_check("edge_past_vector", z_bound, 0, 1'b0);
        report_test("bound_edges");

        set_coeff(Z_WORDS, 0, 0);
        // Magnitude between the r0 and ct0 bounds
        set_coeff(200, 1, `NC_R0_BOUND + 32);
        run_check("r0_flags_gap", r0_bound, 0, 1'b1);
        run_check("ct0_passes_gap", ct0_bound, 0, 1'b0);
        set_coeff(200, 1, 0);
        // Violation only in the eighth polynomial
        set_coeff(K_WORDS - 12, 2, `NC_Q - `NC_Z_BOUND);
        run_check("z_skips_poly_8", z_bound, 0, 1'b0);
        run_check("r0_covers_poly_8", r0_bound, 0, 1'b1);
        set_coeff(K_WORDS - 12, 2, 0);
        report_test("mode_differences");

        // Window writes above the vector while the check runs
        set_coeff(Z_WORDS - 1, 3, `NC_Z_BOUND);
        exp_bad = expected_invalid(z_bound, 0);
        start_check(z_bound, 0);
        fill_region(Z_WORDS, 16, `NC_Z_BOUND);
        read_reg(REG_STATUS, st);
        compare("contention_busy", 32'd1, 32'(st[0]));
        fill_region(Z_WORDS + 16, WIN_WORDS - Z_WORDS - 16, `NC_Z_BOUND);
        maybe_outlier(Z_WORDS, WIN_WORDS - Z_WORDS);
        wait_done(st);
        compare("contention_result", 32'(exp_bad), 32'(st[2]));
        set_coeff(Z_WORDS - 1, 3, 0);
        base = WIN_WORDS - Z_WORDS;
        run_check("after_contention", z_bound, base, expected_invalid(z_bound, base));
        report_test("contention");

        // Zeroize partway through a z vector whose early word is bad
        set_coeff(10, 1, `NC_Z_BOUND);
        start_check(z_bound, 0);
        repeat (100) @(posedge clk);
        #1;
        read_reg(REG_STATUS, st);
        compare("zeroize_busy_before", 32'd1, 32'(st[0]));
        write_reg(REG_CTRL, 32'h8);
        read_reg(REG_STATUS, st);
        compare("zeroize_status", 32'd0, st & 32'h3);
        // Clean vector now, so a flag kept from before zeroize would show
        set_coeff(10, 1, 0);
        run_check("after_zeroize", z_bound, 0, expected_invalid(z_bound, 0));
        report_test("zeroize");

        $display("Checks run %0d, mismatches %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== norm_check_assertions.sv ====
// Generic two-port checks; unused ports tie to zero, so each bind covers only what its target has
`default_nettype none

module norm_check_assertions (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     gnt_a,
    input  logic                     gnt_b,
    input  norm_check_pkg::mem_req_t req_a,
    input  norm_check_pkg::mem_req_t req_b,
    input  logic                     rd_valid,
    input  logic                     flag_a,
    input  logic                     flag_b
);
    import norm_check_pkg::*;

    // One owner of the memory port per cycle
    grant_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(gnt_a && gnt_b)) else $error("both memory grants high");

    // Waiting requests keep address, kind and data
    hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        (req_a.rd_wr_en != RW_IDLE && !gnt_a) |=> $stable(req_a))
        else $error("request A changed before its grant");

    hold_b: assert property (@(posedge clk) disable iff (!reset_n)
        (req_b.rd_wr_en != RW_IDLE && !gnt_b) |=> $stable(req_b))
        else $error("request B changed before its grant");

    // Read data only after a granted read
    read_follows_grant: assert property (@(posedge clk) disable iff (!reset_n)
        rd_valid |-> $past((gnt_a && req_a.rd_wr_en == RW_READ) ||
                           (gnt_b && req_b.rd_wr_en == RW_READ)))
        else $error("rd_valid without a granted read");

    flags_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(flag_a && flag_b)) else $error("busy and done_pulse high together");

endmodule

`default_nettype wire

// ==== norm_check_top.sv ====
// Loader and controller share one memory port; check time grows with AXI window traffic
`default_nettype none

`include "norm_check_config.svh"

module norm_check_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [`NC_AXI_ADDR_W-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`NC_AXI_DATA_W-1:0]   wdata,
    input  logic [`NC_AXI_DATA_W/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`NC_AXI_ADDR_W-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`NC_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);
    import norm_check_pkg::*;

    mem_req_t              ld_req;
    mem_req_t              chk_req;
    mem_req_t              mem_req;
    logic                  ld_gnt;
    logic                  chk_gnt;
    logic [`NC_WORD_W-1:0] mem_rdata;
    logic [`NC_WORD_W-1:0] rd_data;
    logic                  rd_valid;
    nc_start_t             start;
    logic                  zeroize;
    logic                  busy;
    logic                  done_pulse;
    chk_norm_mode_e        mode;
    logic                  result_valid;
    logic                  invalid;

    // Host side
    norm_axil_regs regs0 (
        .clk, .reset_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .ld_req, .ld_gnt, .start, .zeroize,
        .busy, .result_valid, .invalid
    );

    // Read sequencer
    norm_check_ctrl ctrl0 (
        .clk, .reset_n, .zeroize, .start, .chk_gnt,
        .chk_req, .mode, .busy, .done_pulse
    );

    // Port sharing
    coeff_mem_arbiter arb0 (
        .clk, .reset_n, .ld_req, .chk_req, .mem_rdata,
        .ld_gnt, .chk_gnt, .mem_req, .rd_data, .rd_valid
    );

    coeff_mem mem0 (
        .clk,
        .mem_req,
        .rdata (mem_rdata)
    );

    // Bound check datapath
    norm_check_unit unit0 (
        .clk, .reset_n, .zeroize, .rd_valid, .rd_data, .mode, .done_pulse,
        .result_valid, .invalid
    );

endmodule

`default_nettype wire

// ==== norm_axil_regs.sv ====
// One transaction per channel; window is write-only, lanes 0-2 must precede lane 3 of a word
`default_nettype none

`include "norm_check_config.svh"

module norm_axil_regs (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [`NC_AXI_ADDR_W-1:0]      awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [`NC_AXI_DATA_W-1:0]      wdata,
    input  logic [`NC_AXI_DATA_W/8-1:0]    wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [`NC_AXI_ADDR_W-1:0]      araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [`NC_AXI_DATA_W-1:0]      rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output norm_check_pkg::mem_req_t       ld_req,
    input  logic                           ld_gnt,
    output norm_check_pkg::nc_start_t      start,
    output logic                           zeroize,
    input  logic                           busy,
    input  logic                           result_valid,
    input  logic                           invalid
);
    import norm_check_pkg::*;

    localparam int DATA_W    = `NC_AXI_DATA_W;
    localparam int CW        = `NC_COEFF_W;
    localparam int LANE_W    = $clog2(`NC_LANES);
    localparam int LAST_LANE = `NC_LANES - 1;

    logic [CW-1:0]             stage [LAST_LANE];
    logic [`NC_ADDR_W-1:0]     base_q;
    nc_status_t                status_q;
    logic [`NC_AXI_ADDR_W-1:0] win_off;
    logic [LANE_W-1:0]         lane;
    logic                      win_hit;
    logic                      ld_pend;
    logic                      wr_accept;
    logic                      wr_do;
    logic                      ctrl_wr;
    logic                      start_ok;
    logic                      issue_word;

    // Window decode
    assign win_hit = (awaddr >= WIN_BASE);
    assign win_off = awaddr - WIN_BASE;
    assign lane    = win_off[LANE_W+1:2];

    // AW and W taken together, none while a response or word write is open
    assign ld_pend   = (ld_req.rd_wr_en != RW_IDLE);
    assign wr_accept = awvalid && wvalid && !bvalid && !ld_pend;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    // Writes with no strobes are answered but change nothing
    assign wr_do     = wr_accept && (|wstrb);
    assign ctrl_wr   = wr_do && (awaddr == REG_CTRL);
    assign start_ok  = ctrl_wr && wdata[0] && !wdata[3] && !status_q.busy && !busy;
    assign issue_word = wr_do && win_hit && (lane == LANE_W'(LAST_LANE));

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // Staging for the low lanes of a word
    always_ff @(posedge clk) begin
        if (wr_do && win_hit && lane != LANE_W'(LAST_LANE)) begin
            stage[lane] <= wdata[CW-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ld_req   <= '0;
            bvalid   <= 1'b0;
            base_q   <= '0;
            status_q <= '0;
            start    <= '0;
            zeroize  <= 1'b0;
        end else begin
            start.start <= start_ok;
            zeroize     <= ctrl_wr && wdata[3];
            if (start_ok) begin
                start.mode <= chk_norm_mode_e'(wdata[2:1]);
                start.base <= base_q;
            end
            if (wr_do && awaddr == REG_BASE) begin
                base_q <= wdata[`NC_ADDR_W-1:0];
            end

            // Write response
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_accept && !issue_word) begin
                bvalid <= 1'b1;
            end

            // Lane 3 completes the word, response waits for the grant
            if (issue_word) begin
                ld_req.addr     <= win_off[`NC_ADDR_W+3:4];
                ld_req.rd_wr_en <= RW_WRITE;
                for (int i = 0; i < LAST_LANE; i++) begin
                    ld_req.wdata[i*CW +: CW] <= stage[i];
                end
                ld_req.wdata[LAST_LANE*CW +: CW] <= wdata[CW-1:0];
            end
            if (ld_pend && ld_gnt) begin
                ld_req.rd_wr_en <= RW_IDLE;
                bvalid          <= 1'b1;
            end

            // Sticky status, done held until the next start
            if (start_ok) begin
                status_q <= '{invalid: 1'b0, done: 1'b0, busy: 1'b1};
            end else if (zeroize) begin
                status_q <= '0;
            end else if (result_valid) begin
                status_q <= '{invalid: invalid, done: 1'b1, busy: 1'b0};
            end
        end
    end

    // Read channel, data returned the cycle after arvalid
    assign arready = arvalid && !rvalid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arready) begin
                rvalid <= 1'b1;
                case (araddr)
                    REG_BASE:   rdata <= DATA_W'(base_q);
                    REG_STATUS: rdata <= DATA_W'(status_q);
                    // CTRL and the window read as zero
                    default:    rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== coeff_mem.sv ====
// Single port, read and write never in the same cycle; contents are not cleared by reset
`default_nettype none

`include "norm_check_config.svh"

module coeff_mem (
    input  logic                     clk,
    input  norm_check_pkg::mem_req_t mem_req,
    output logic [`NC_WORD_W-1:0]    rdata
);
    import norm_check_pkg::*;

    logic [`NC_WORD_W-1:0] mem [`NC_MEM_DEPTH];

    // One-cycle read latency
    always_ff @(posedge clk) begin
        if (mem_req.rd_wr_en == RW_WRITE) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
        if (mem_req.rd_wr_en == RW_READ) begin
            rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

// ==== coeff_mem_arbiter.sv ====
// Two requesters only; rd_data is valid solely in the rd_valid cycle
`default_nettype none

`include "norm_check_config.svh"

module coeff_mem_arbiter (
    input  logic                     clk,
    input  logic                     reset_n,
    input  norm_check_pkg::mem_req_t ld_req,
    input  norm_check_pkg::mem_req_t chk_req,
    input  logic [`NC_WORD_W-1:0]    mem_rdata,
    output logic                     ld_gnt,
    output logic                     chk_gnt,
    output norm_check_pkg::mem_req_t mem_req,
    output logic [`NC_WORD_W-1:0]    rd_data,
    output logic                     rd_valid
);
    import norm_check_pkg::*;

    logic ld_act;
    logic chk_act;
    logic last_chk;

    assign ld_act  = (ld_req.rd_wr_en != RW_IDLE);
    assign chk_act = (chk_req.rd_wr_en != RW_IDLE);

    // Controller wins unless both want the port and it won last
    assign chk_gnt = chk_act && (!ld_act || !last_chk);
    assign ld_gnt  = ld_act && !chk_gnt;

    always_comb begin
        mem_req = '0;
        if (chk_gnt) begin
            mem_req = chk_req;
        end else if (ld_gnt) begin
            mem_req = ld_req;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Loader counts as last winner so the controller goes first
            last_chk <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (chk_gnt || ld_gnt) begin
                last_chk <= chk_gnt;
            end
            // Memory read data lands one cycle after the granted read
            rd_valid <= (mem_req.rd_wr_en == RW_READ);
        end
    end

    assign rd_data = mem_rdata;

endmodule

`default_nettype wire

// ==== norm_check_unit.sv ====
// Expects the last read word in the same cycle as done_pulse; result is one cycle later
`default_nettype none

`include "norm_check_config.svh"

module norm_check_unit (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    input  logic                           rd_valid,
    input  logic [`NC_WORD_W-1:0]          rd_data,
    input  norm_check_pkg::chk_norm_mode_e mode,
    input  logic                           done_pulse,
    output logic                           result_valid,
    output logic                           invalid
);
    import norm_check_pkg::*;

    localparam logic [`NC_COEFF_W-1:0] Q      = `NC_Q;
    localparam logic [`NC_COEFF_W-1:0] HALF_Q = (`NC_Q - 1) / 2;

    logic [`NC_COEFF_W-1:0] bound;
    logic [`NC_COEFF_W-1:0] coeff;
    logic [`NC_COEFF_W-1:0] mag;
    logic [`NC_LANES-1:0]   lane_viol;
    logic                   word_viol;
    logic                   acc;

    // Bound for the latched mode
    always_comb begin
        case (mode)
            z_bound:   bound = `NC_Z_BOUND;
            r0_bound:  bound = `NC_R0_BOUND;
            ct0_bound: bound = `NC_CT0_BOUND;
            default:   bound = Q;
        endcase
    end

    // Centered magnitude per lane, out-of-range coefficients flagged too
    always_comb begin
        lane_viol = '0;
        coeff     = '0;
        mag       = '0;
        for (int i = 0; i < `NC_LANES; i++) begin
            coeff        = rd_data[i*`NC_COEFF_W +: `NC_COEFF_W];
            mag          = (coeff <= HALF_Q) ? coeff : Q - coeff;
            lane_viol[i] = (coeff >= Q) || (mag >= bound);
        end
    end

    assign word_viol = rd_valid && (|lane_viol);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc          <= 1'b0;
            result_valid <= 1'b0;
            invalid      <= 1'b0;
        end else if (zeroize) begin
            acc          <= 1'b0;
            result_valid <= 1'b0;
            invalid      <= 1'b0;
        end else begin
            result_valid <= done_pulse;
            if (done_pulse) begin
                // Fold in the final word, then start clean
                invalid <= acc | word_viol;
                acc     <= 1'b0;
            end else if (word_viol) begin
                acc <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== norm_check_ctrl.sv ====
// Vector must sit in contiguous words from base; a new start is only taken in idle
`default_nettype none

`include "norm_check_config.svh"

module norm_check_ctrl (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    input  norm_check_pkg::nc_start_t      start,
    input  logic                           chk_gnt,
    output norm_check_pkg::mem_req_t       chk_req,
    output norm_check_pkg::chk_norm_mode_e mode,
    output logic                           busy,
    output logic                           done_pulse
);
    import norm_check_pkg::*;

    localparam int WORDS_PER_POLY = `NC_N / `NC_LANES;

    chk_read_state_e       state;
    chk_read_state_e       state_nxt;
    logic [`NC_ADDR_W-1:0] base_q;
    logic [`NC_ADDR_W-1:0] offset;
    logic                  last_word;

    // Words in the vector for a mode
    function automatic int vector_words(input chk_norm_mode_e m);
        case (m)
            z_bound:   return `NC_L * WORDS_PER_POLY;
            r0_bound:  return `NC_K * WORDS_PER_POLY;
            ct0_bound: return `NC_K * WORDS_PER_POLY;
            default:   return 0;
        endcase
    endfunction

    assign last_word = (int'(offset) == vector_words(mode) - 1);

    always_comb begin
        state_nxt = state;
        case (state)
            CHK_IDLE: begin
                // Empty vector goes straight to done
                if (start.start) begin
                    state_nxt = (vector_words(start.mode) == 0) ? CHK_DONE : CHK_RD_MEM;
                end
            end
            CHK_RD_MEM: begin
                if (chk_gnt && last_word) begin
                    state_nxt = CHK_DONE;
                end
            end
            CHK_DONE: state_nxt = CHK_IDLE;
            default:  state_nxt = CHK_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= CHK_IDLE;
            mode   <= z_bound;
            base_q <= '0;
            offset <= '0;
        end else if (zeroize) begin
            state  <= CHK_IDLE;
            offset <= '0;
        end else begin
            state <= state_nxt;
            if (state == CHK_IDLE && start.start) begin
                mode   <= start.mode;
                base_q <= start.base;
                offset <= '0;
            end else if (state == CHK_RD_MEM && chk_gnt) begin
                // Advance only when the arbiter took this address
                offset <= last_word ? '0 : offset + 1'b1;
            end
        end
    end

    // Request held steady until granted
    always_comb begin
        chk_req.addr     = base_q + offset;
        chk_req.rd_wr_en = (state == CHK_RD_MEM) ? RW_READ : RW_IDLE;
        chk_req.wdata    = '0;
    end

    assign busy       = (state == CHK_RD_MEM);
    assign done_pulse = (state == CHK_DONE);

endmodule

`default_nettype wire

// ==== norm_check_pkg.sv ====
// Types shared by the norm check blocks; struct widths follow the config header values
`default_nettype none

`include "norm_check_config.svh"

package norm_check_pkg;

    // Bound mode; last code selects no polynomials
    typedef enum logic [1:0] {
        z_bound   = 2'd0,
        r0_bound  = 2'd1,
        ct0_bound = 2'd2,
        zero_poly = 2'd3
    } chk_norm_mode_e;

    typedef enum logic [1:0] {
        CHK_IDLE,
        CHK_RD_MEM,
        CHK_DONE
    } chk_read_state_e;

    typedef enum logic [1:0] {
        RW_IDLE,
        RW_READ,
        RW_WRITE
    } rw_e;

    // One memory port request, a full word wide
    typedef struct packed {
        logic [`NC_ADDR_W-1:0] addr;
        rw_e                   rd_wr_en;
        logic [`NC_WORD_W-1:0] wdata;
    } mem_req_t;

    // Start command from the register block
    typedef struct packed {
        logic                  start;
        chk_norm_mode_e        mode;
        logic [`NC_ADDR_W-1:0] base;
    } nc_start_t;

    // Busy sits in bit 0 to match the STATUS layout
    typedef struct packed {
        logic invalid;
        logic done;
        logic busy;
    } nc_status_t;

    // Byte offsets on the AXI port
    localparam logic [`NC_AXI_ADDR_W-1:0] REG_CTRL   = 'h000;
    localparam logic [`NC_AXI_ADDR_W-1:0] REG_BASE   = 'h004;
    localparam logic [`NC_AXI_ADDR_W-1:0] REG_STATUS = 'h008;
    localparam logic [`NC_AXI_ADDR_W-1:0] WIN_BASE   = 'h1000;

endpackage

`default_nettype wire

// ==== norm_check_config.svh ====
// Sizes for ML-DSA-87 vectors only; word layout assumes 4 lanes of 24 bits and depth of 2**NC_ADDR_W
`ifndef NORM_CHECK_CONFIG_SVH
`define NORM_CHECK_CONFIG_SVH

// Polynomial geometry
`define NC_N            256
`define NC_L            7
`define NC_K            8
`define NC_Q            8380417

// Memory word layout
`define NC_COEFF_W      24
`define NC_LANES        4
`define NC_WORD_W       96
`define NC_MEM_DEPTH    1024
`define NC_ADDR_W       10

// Bounds per mode: gamma1-beta, gamma2-beta, gamma2
`define NC_Z_BOUND      524168
`define NC_R0_BOUND     261768
`define NC_CT0_BOUND    261888

// AXI4-Lite port
`define NC_AXI_ADDR_W   14
`define NC_AXI_DATA_W   32

`endif
